//--- Bender.yml
package:
  name: spi_hub

sources:
  - include_dirs:
      - common
    files:
      - common/spi_hub_pkg.sv
      - common/spi_port_if.sv
      - spi_slave/spi_slave_port.sv
      - hdl/reply_dispatch.sv
      - hdl/rx_collector.sv
      - hdl/spi_hub_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - dv/spi_hub_tb.sv

//--- common/spi_hub_pkg.sv
`include "spi_hub_settings.svh"

package spi_hub_pkg;

  // ----------------------------------------------------------------------
  // data types
  // ----------------------------------------------------------------------

  // one frame, msb first on the wire
  typedef logic [`SPI_HUB_WORD_BITS-1:0] spi_word_t;

  // index of a slave port
  typedef logic [`SPI_HUB_PORT_BITS-1:0] port_id_t;

  // ----------------------------------------------------------------------
  // slave frame fsm
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_shift,
    st_finish
  } slave_state_e;

endpackage

//--- common/spi_hub_settings.svh
`ifndef SPI_HUB_SETTINGS_SVH
`define SPI_HUB_SETTINGS_SVH

// ----------------------------------------------------------------------
// hub sizing
// ----------------------------------------------------------------------

// slave ports on the hub
`define SPI_HUB_NUM_PORTS 4

// bytes shifted per select
`define SPI_HUB_NBYTES 1

// derived widths
`define SPI_HUB_WORD_BITS (8 * `SPI_HUB_NBYTES)

// port index width, never below one bit
`define SPI_HUB_PORT_BITS \
  (($clog2(`SPI_HUB_NUM_PORTS) > 0) ? $clog2(`SPI_HUB_NUM_PORTS) : 1)

`endif

//--- common/spi_port_if.sv
`timescale 1ns/10ps

interface spi_port_if import spi_hub_pkg::*; ();

  // reply path, dispatcher to slave
  spi_word_t tx_word;
  logic      tx_load;

  // frame begins
  logic      start;

  // receive path, slave to collector
  spi_word_t rx_word;
  logic      rx_valid;
  logic      rx_overrun;
  logic      rx_ready;

  modport slave (
    input  tx_word,
    input  tx_load,
    output start,
    output rx_word,
    output rx_valid,
    output rx_overrun,
    input  rx_ready
  );

  modport dispatch (
    output tx_word,
    output tx_load,
    input  start
  );

  modport collect (
    input  rx_word,
    input  rx_valid,
    input  rx_overrun,
    output rx_ready
  );

endinterface

//--- dv/spi_hub_tb.sv
`timescale 1ns/10ps

`include "spi_hub_settings.svh"

module spi_hub_tb import spi_hub_pkg::*;
();

  localparam int NUM_PORTS    = `SPI_HUB_NUM_PORTS;
  localparam int WORD_BITS    = `SPI_HUB_WORD_BITS;
  localparam int HALF_BIT     = 8;
  localparam int BUSY_TIMEOUT = 16;
  localparam int TX_TIMEOUT   = 32;
  localparam int RX_TIMEOUT   = 64;
  localparam int RAND_SEED    = 55504;

  logic                 sendclk = 1'b0;
  logic                 reset;
  logic                 cpol;
  logic                 cpha;
  logic [NUM_PORTS-1:0] spi_select;
  logic [NUM_PORTS-1:0] spi_mclk;
  logic [NUM_PORTS-1:0] spi_mosi;
  logic [NUM_PORTS-1:0] spi_miso;
  logic [NUM_PORTS-1:0] busy;
  logic                 tx_valid;
  logic                 tx_ready;
  port_id_t             tx_port;
  spi_word_t            tx_data;
  logic                 rx_valid;
  logic                 rx_ready;
  port_id_t             rx_port;
  spi_word_t            rx_data;
  logic                 rx_overrun;

  // model of the collector output register
  logic                 out_valid;
  port_id_t             out_port;
  spi_word_t            out_word;
  logic                 out_ovr;

  // model of the port holding registers
  logic [NUM_PORTS-1:0] hold_valid;
  logic [NUM_PORTS-1:0] hold_ovr;
  spi_word_t            hold_word [NUM_PORTS];

  int err_count;
  int test_count;
  int fail_count;
  bit timed_out;

  always #20 sendclk = ~sendclk;

  spi_hub_top i_dut (
    .sendclk    (sendclk),
    .reset      (reset),
    .cpol       (cpol),
    .cpha       (cpha),
    .spi_select (spi_select),
    .spi_mclk   (spi_mclk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso),
    .busy       (busy),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .tx_port    (tx_port),
    .tx_data    (tx_data),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .rx_port    (rx_port),
    .rx_data    (rx_data),
    .rx_overrun (rx_overrun)
  );

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------

  task automatic check_word(input string test, input string what,
                            input spi_word_t exp, input spi_word_t act);
    if (act !== exp)
    begin
      err_count++;
      $display("Error %s: %s expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic check_port(input string test, input port_id_t exp, input port_id_t act);
    if (act !== exp)
    begin
      err_count++;
      $display("Error %s: rx_port expected %0d, actual %0d", test, exp, act);
    end
  endtask

  task automatic check_flag(input string test, input string what,
                            input logic exp, input logic act);
    if (act !== exp)
    begin
      err_count++;
      $display("Error %s: %s expected %b, actual %b", test, what, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    err_count++;
    timed_out = 1'b1;
    $display("timeout while waiting for %s", what);
  endtask

  // ----------------------------------------------------------------------
  // spi master
  // ----------------------------------------------------------------------

  task automatic half_bit();
    repeat (HALF_BIT) @(posedge sendclk);
  endtask

  // shared mode lines only change with all ports idle
  task automatic set_mode(input logic pol, input logic pha);
    if (pol !== cpol || pha !== cpha)
    begin
      @(posedge sendclk);
      cpol     <= pol;
      cpha     <= pha;
      spi_mclk <= {NUM_PORTS{pol}};
      repeat (4) @(posedge sendclk);
    end
  endtask

  task automatic run_frame(input string test, input port_id_t p, input logic pol,
                           input logic pha, input spi_word_t mosi_w,
                           input logic ready_check, output spi_word_t miso_w);
    int guard;
    int b;
    miso_w = '1;
    guard  = 0;
    @(posedge sendclk);
    spi_select[p] <= 1'b1;
    // cpha 0 has the first bit on mosi before the first edge
    if (!pha)
      spi_mosi[p] <= mosi_w[WORD_BITS-1];
    @(negedge sendclk);
    while (!busy[p] && !timed_out)
    begin
      guard++;
      if (guard > BUSY_TIMEOUT)
        report_timeout($sformatf("busy on port %0d", p));
      else
        @(negedge sendclk);
    end
    if (timed_out)
      return;
    // slot empties in the start cycle
    if (ready_check)
    begin
      @(negedge sendclk);
      check_flag(test, "tx_ready after start", 1'b1, tx_ready);
    end
    half_bit();
    for (b = WORD_BITS - 1; b >= 0; b--)
    begin
      check_flag(test, "busy in frame", 1'b1, busy[p]);
      spi_mclk[p] <= ~pol;
      if (pha)
        spi_mosi[p] <= mosi_w[b];
      else
        miso_w[b] = spi_miso[p];
      half_bit();
      spi_mclk[p] <= pol;
      if (pha)
        miso_w[b] = spi_miso[p];
      else if (b > 0)
        spi_mosi[p] <= mosi_w[b-1];
      half_bit();
    end
    spi_select[p] <= 1'b0;
    spi_mosi[p]   <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // reply input
  // ----------------------------------------------------------------------

  task automatic send_reply(input port_id_t p, input spi_word_t w);
    int guard;
    guard = 0;
    @(posedge sendclk);
    tx_valid <= 1'b1;
    tx_port  <= p;
    tx_data  <= w;
    @(negedge sendclk);
    while (!tx_ready && !timed_out)
    begin
      guard++;
      if (guard > TX_TIMEOUT)
        report_timeout($sformatf("tx_ready for port %0d", p));
      else
        @(negedge sendclk);
    end
    @(posedge sendclk);
    tx_valid <= 1'b0;
  endtask

  // a second reply to a full slot is offered and withdrawn
  task automatic offer_second_reply(input string test, input port_id_t p, input spi_word_t w);
    @(posedge sendclk);
    tx_valid <= 1'b1;
    tx_port  <= p;
    tx_data  <= ~w;
    repeat (3)
    begin
      @(negedge sendclk);
      check_flag(test, "tx_ready with slot full", 1'b0, tx_ready);
    end
    @(posedge sendclk);
    tx_valid <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // receive side
  // ----------------------------------------------------------------------

  // first word after a drain goes straight to the output register
  task automatic record_frame(input port_id_t p, input spi_word_t w);
    logic ovr;
    ovr = hold_valid[p];
    if (!out_valid)
    begin
      out_valid = 1'b1;
      out_port  = p;
      out_word  = w;
      out_ovr   = ovr;
    end
    else
    begin
      hold_valid[p] = 1'b1;
      hold_word[p]  = w;
      hold_ovr[p]   = ovr;
    end
  endtask

  task automatic take_word(input string test);
    spi_word_t exp_word;
    logic      exp_ovr;
    if (out_valid)
    begin
      check_port(test, out_port, rx_port);
      exp_word  = out_word;
      exp_ovr   = out_ovr;
      out_valid = 1'b0;
    end
    else if (hold_valid[rx_port])
    begin
      // held words may come in any order
      exp_word            = hold_word[rx_port];
      exp_ovr             = hold_ovr[rx_port];
      hold_valid[rx_port] = 1'b0;
    end
    else
    begin
      err_count++;
      $display("%s: a word arrived from port %0d with none pending", test, rx_port);
      return;
    end
    check_word(test, "rx_data", exp_word, rx_data);
    check_flag(test, "rx_overrun", exp_ovr, rx_overrun);
    check_flag(test, "busy after rx_valid", 1'b0, busy[rx_port]);
  endtask

  task automatic drain_words(input string test);
    int expected;
    int got;
    int guard;
    int i;
    expected = out_valid ? 1 : 0;
    for (i = 0; i < NUM_PORTS; i++)
      if (hold_valid[i])
        expected++;
    got   = 0;
    guard = 0;
    @(posedge sendclk);
    rx_ready <= 1'b1;
    while (got < expected && !timed_out)
    begin
      @(negedge sendclk);
      if (rx_valid)
      begin
        take_word(test);
        got++;
        guard = 0;
        @(posedge sendclk);
      end
      else
      begin
        guard++;
        if (guard > RX_TIMEOUT)
          report_timeout("rx_valid");
      end
    end
    repeat (4)
    begin
      @(negedge sendclk);
      if (rx_valid)
      begin
        err_count++;
        $display("%s: an extra word arrived from port %0d", test, rx_port);
      end
    end
    @(posedge sendclk);
    rx_ready <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // one line of test data
  // ----------------------------------------------------------------------

  task automatic run_test(input string name, input logic pol, input logic pha,
                          input port_id_t p, input spi_word_t mosi_w,
                          input logic has_reply, input spi_word_t reply_w, input logic hold);
    int        err_before;
    spi_word_t exp_miso;
    spi_word_t miso_w;
    err_before = err_count;
    exp_miso   = '1;
    set_mode(pol, pha);
    if (has_reply)
    begin
      send_reply(p, reply_w);
      offer_second_reply(name, p, reply_w);
      exp_miso = reply_w;
    end
    if (!timed_out)
      run_frame(name, p, pol, pha, mosi_w, has_reply, miso_w);
    if (!timed_out)
    begin
      check_word(name, "miso word", exp_miso, miso_w);
      record_frame(p, mosi_w);
      if (!hold)
        drain_words(name);
      repeat (4 + ($urandom % 8)) @(posedge sendclk);
    end
    test_count++;
    if (err_count != err_before)
    begin
      fail_count++;
      $display("test %s failed", name);
    end
    else
      $display("test %s ok", name);
  endtask

  initial
  begin
    int          fd;
    int          rc;
    int          n;
    int          line_no;
    int          pol_i;
    int          pha_i;
    int          port_i;
    int          hold_i;
    int unsigned rnd;
    string       line;
    string       reply_s;
    spi_word_t   mosi_w;
    spi_word_t   reply_w;
    reset      = 1'b1;
    cpol       = 1'b0;
    cpha       = 1'b0;
    spi_select = '0;
    spi_mclk   = '0;
    spi_mosi   = '0;
    tx_valid   = 1'b0;
    tx_port    = '0;
    tx_data    = '0;
    rx_ready   = 1'b0;
    out_valid  = 1'b0;
    out_port   = '0;
    out_word   = '0;
    out_ovr    = 1'b0;
    hold_valid = '0;
    hold_ovr   = '0;
    err_count  = 0;
    test_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;
    line_no    = 0;
    rnd        = $urandom(RAND_SEED);
    repeat (2) @(posedge sendclk);
    reset <= 1'b0;
    repeat (4) @(posedge sendclk);

    fd = $fopen("dv/spi_hub_testdata.txt", "r");
    if (fd == 0)
    begin
      err_count++;
      $display("could not open dv/spi_hub_testdata.txt");
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        line = "";
        rc   = $fgets(line, fd);
        line_no++;
        if (line.len() > 0 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%d %d %d %h %s %d",
                      pol_i, pha_i, port_i, mosi_w, reply_s, hold_i);
          if (n == 6)
          begin
            if (reply_s == "none")
              reply_w = '1;
            else
              rc = $sscanf(reply_s, "%h", reply_w);
            run_test($sformatf("line%0d_mode%0d_port%0d", line_no, pol_i * 2 + pha_i, port_i),
                     pol_i[0], pha_i[0], port_id_t'(port_i), mosi_w,
                     reply_s != "none", reply_w, hold_i[0]);
          end
          else if (n > 0)
          begin
            err_count++;
            $display("test data line %0d could not be read", line_no);
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d failed, %0d errors", test_count, fail_count, err_count);
    if (err_count == 0 && !timed_out && test_count > 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- dv/spi_hub_testdata.txt
# cpol cpha port master_word reply_word hold
# reply_word is hex or none, hold 1 leaves the word undelivered until a hold 0 line
# one port in each of the four modes
0 0 0 a5 3c 0
0 1 1 5a c3 0
1 0 2 96 e1 0
1 1 3 69 1e 0
# no reply queued
0 0 2 0f none 0
1 1 0 f0 none 0
# all ports back to back, drained together
0 1 0 11 81 1
0 1 1 22 42 1
0 1 2 33 none 1
0 1 3 44 24 0
# port 2 fills the output register, port 1 then overruns
1 0 2 55 aa 1
1 0 1 66 99 1
1 0 1 77 88 0
# single frames again, overrun clear
1 0 1 c8 37 0
0 0 3 01 fe 0
1 1 2 80 7f 0
0 1 3 ff 00 0
# overrun on port 0 in mode 3
1 1 3 12 none 1
1 1 0 34 56 1
1 1 0 9c 63 0
0 0 1 3e c1 0

//--- hdl/reply_dispatch.sv
`timescale 1ns/10ps

`include "spi_hub_settings.svh"

module reply_dispatch import spi_hub_pkg::*;
(
  input  logic         sendclk,
  input  logic         reset,
  input  logic         tx_valid,
  output logic         tx_ready,
  input  port_id_t     tx_port,
  input  spi_word_t    tx_data,
  spi_port_if.dispatch ports [`SPI_HUB_NUM_PORTS]
);

  localparam int NUM_PORTS = `SPI_HUB_NUM_PORTS;

  spi_word_t            slot_data [NUM_PORTS];
  logic [NUM_PORTS-1:0] slot_full;
  logic [NUM_PORTS-1:0] start_vec;
  logic                 accept;

  // ----------------------------------------------------------------------
  // reply slots
  // ----------------------------------------------------------------------

  // one reply per port at a time
  assign tx_ready = !slot_full[tx_port];
  assign accept   = tx_valid && tx_ready;

  always_ff @(posedge sendclk)
  begin
    if (reset)
      slot_full <= '0;
    else
    begin
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        if (accept && tx_port == port_id_t'(i))
          slot_full[i] <= 1'b1;
        else if (start_vec[i])
          slot_full[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge sendclk)
  begin
    if (accept)
      slot_data[tx_port] <= tx_data;
  end

  // ----------------------------------------------------------------------
  // hand-off at frame start
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_port
    assign start_vec[i]     = ports[i].start;
    assign ports[i].tx_load = ports[i].start && slot_full[i];
    assign ports[i].tx_word = slot_data[i];

    // a queued reply survives until its own frame takes it
    a_slot_kept: assert property (
      @(posedge sendclk) disable iff (reset)
      slot_full[i] && !start_vec[i] |=> slot_full[i] && $stable(slot_data[i])
    ) else $error("reply slot %0d overwritten before its frame", i);
  end

endmodule

//--- hdl/rx_collector.sv
`timescale 1ns/10ps

`include "spi_hub_settings.svh"

module rx_collector import spi_hub_pkg::*;
(
  input  logic        sendclk,
  input  logic        reset,
  spi_port_if.collect ports [`SPI_HUB_NUM_PORTS],
  output logic        rx_valid,
  input  logic        rx_ready,
  output port_id_t    rx_port,
  output spi_word_t   rx_data,
  output logic        rx_overrun
);

  localparam int NUM_PORTS = `SPI_HUB_NUM_PORTS;

  logic [NUM_PORTS-1:0] valid_vec;
  logic [NUM_PORTS-1:0] overrun_vec;
  spi_word_t            word_arr [NUM_PORTS];
  port_id_t             last_port;
  port_id_t             grant_port;
  port_id_t             cand;
  logic                 grant_found;
  logic                 out_free;

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_port
    assign valid_vec[i]      = ports[i].rx_valid;
    assign overrun_vec[i]    = ports[i].rx_overrun;
    assign word_arr[i]       = ports[i].rx_word;
    assign ports[i].rx_ready = out_free && grant_found && grant_port == port_id_t'(i);
  end

  // ----------------------------------------------------------------------
  // round-robin pick
  // ----------------------------------------------------------------------

  // output register empty or being drained this cycle
  assign out_free = !rx_valid || rx_ready;

  // search starts one past the last port served
  always_comb
  begin
    grant_found = 1'b0;
    grant_port  = last_port;
    cand        = last_port;
    for (int k = 1; k <= NUM_PORTS; k++)
    begin
      cand = port_id_t'((int'(last_port) + k) % NUM_PORTS);
      if (!grant_found && valid_vec[cand])
      begin
        grant_found = 1'b1;
        grant_port  = cand;
      end
    end
  end

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------

  always_ff @(posedge sendclk)
  begin
    if (reset)
    begin
      rx_valid  <= 1'b0;
      last_port <= port_id_t'(NUM_PORTS - 1);
    end
    else if (out_free)
    begin
      rx_valid <= grant_found;
      if (grant_found)
        last_port <= grant_port;
    end
  end

  always_ff @(posedge sendclk)
  begin
    if (out_free && grant_found)
    begin
      rx_port    <= grant_port;
      rx_data    <= word_arr[grant_port];
      rx_overrun <= overrun_vec[grant_port];
    end
  end

  a_hold_under_stall: assert property (
    @(posedge sendclk) disable iff (reset)
    rx_valid && !rx_ready |=>
      rx_valid && $stable(rx_port) && $stable(rx_data) && $stable(rx_overrun)
  ) else $error("receive output changed under back-pressure");

endmodule

//--- hdl/spi_hub_top.sv
`timescale 1ns/10ps

`include "spi_hub_settings.svh"

module spi_hub_top import spi_hub_pkg::*;
(
  input  logic                          sendclk,
  input  logic                          reset,

  // shared spi mode
  input  logic                          cpol,
  input  logic                          cpha,

  // spi pins, one bit per port
  input  logic [`SPI_HUB_NUM_PORTS-1:0] spi_select,
  input  logic [`SPI_HUB_NUM_PORTS-1:0] spi_mclk,
  input  logic [`SPI_HUB_NUM_PORTS-1:0] spi_mosi,
  output logic [`SPI_HUB_NUM_PORTS-1:0] spi_miso,
  output logic [`SPI_HUB_NUM_PORTS-1:0] busy,

  // reply input
  input  logic                          tx_valid,
  output logic                          tx_ready,
  input  port_id_t                      tx_port,
  input  spi_word_t                     tx_data,

  // received words
  output logic                          rx_valid,
  input  logic                          rx_ready,
  output port_id_t                      rx_port,
  output spi_word_t                     rx_data,
  output logic                          rx_overrun
);

  spi_port_if port_bus [`SPI_HUB_NUM_PORTS] ();

  // ----------------------------------------------------------------------
  // reply slots
  // ----------------------------------------------------------------------

  reply_dispatch u_dispatch (
    .sendclk  (sendclk),
    .reset    (reset),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_port  (tx_port),
    .tx_data  (tx_data),
    .ports    (port_bus)
  );

  // ----------------------------------------------------------------------
  // slave ports
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < `SPI_HUB_NUM_PORTS; i++)
  begin : g_slave
    spi_slave_port u_port (
      .sendclk (sendclk),
      .reset   (reset),
      .cpol    (cpol),
      .cpha    (cpha),
      .select  (spi_select[i]),
      .mclk    (spi_mclk[i]),
      .mosi    (spi_mosi[i]),
      .miso    (spi_miso[i]),
      .busy    (busy[i]),
      .port    (port_bus[i])
    );
  end

  // ----------------------------------------------------------------------
  // receive drain
  // ----------------------------------------------------------------------

  rx_collector u_collect (
    .sendclk    (sendclk),
    .reset      (reset),
    .ports      (port_bus),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .rx_port    (rx_port),
    .rx_data    (rx_data),
    .rx_overrun (rx_overrun)
  );

endmodule

//--- sim.f
+incdir+common
common/spi_hub_pkg.sv
common/spi_port_if.sv
spi_slave/spi_slave_port.sv
hdl/reply_dispatch.sv
hdl/rx_collector.sv
hdl/spi_hub_top.sv
dv/spi_hub_tb.sv

//--- spi_slave/spi_slave_port.sv
`timescale 1ns/10ps

`include "spi_hub_settings.svh"

module spi_slave_port import spi_hub_pkg::*;
(
  input  logic      sendclk,
  input  logic      reset,
  input  logic      cpol,
  input  logic      cpha,
  input  logic      select,
  input  logic      mclk,
  input  logic      mosi,
  output logic      miso,
  output logic      busy,
  spi_port_if.slave port
);

  localparam int WORD_BITS = `SPI_HUB_WORD_BITS;
  localparam int CNT_BITS  = $clog2(WORD_BITS);

  logic [1:0]          select_sync;
  logic [1:0]          mclk_sync;
  logic [1:0]          mosi_sync;
  logic                select_prev;
  logic                phase;
  logic                phase_prev;
  logic                select_rise;
  logic                lead_edge;
  logic                trail_edge;
  logic                sample_edge;
  logic                shift_edge;
  slave_state_e        state;
  logic [CNT_BITS-1:0] bit_cnt;
  spi_word_t           load_word;
  spi_word_t           tx_shift;
  spi_word_t           rx_shift;
  spi_word_t           rx_hold;
  logic                miso_q;
  logic                rx_valid_q;
  logic                rx_overrun_q;

  // ----------------------------------------------------------------------
  // pin synchronizers and edge detect
  // ----------------------------------------------------------------------

  always_ff @(posedge sendclk)
  begin
    if (reset)
    begin
      select_sync <= '0;
      mclk_sync   <= '0;
      mosi_sync   <= '0;
      select_prev <= 1'b0;
      phase_prev  <= 1'b0;
    end
    else
    begin
      select_sync <= {select_sync[0], select};
      mclk_sync   <= {mclk_sync[0], mclk};
      mosi_sync   <= {mosi_sync[0], mosi};
      select_prev <= select_sync[1];
      phase_prev  <= phase;
    end
  end

  // mclk relative to its idle level
  assign phase       = mclk_sync[1] ^ cpol;
  assign select_rise = select_sync[1] & ~select_prev;
  assign lead_edge   = phase & ~phase_prev;
  assign trail_edge  = ~phase & phase_prev;

  // cpha 0 samples on the leading edge, cpha 1 on the trailing one
  assign sample_edge = cpha ? trail_edge : lead_edge;
  assign shift_edge  = cpha ? lead_edge : trail_edge;

  // ----------------------------------------------------------------------
  // frame fsm
  // ----------------------------------------------------------------------

  always_ff @(posedge sendclk)
  begin
    if (reset)
    begin
      state   <= st_idle;
      bit_cnt <= '0;
    end
    else
    begin
      case (state)
        st_idle:
          if (select_rise)
            state <= st_start;
        st_start:
        begin
          bit_cnt <= '0;
          state   <= select_sync[1] ? st_shift : st_idle;
        end
        st_shift:
          if (!select_sync[1])
            state <= st_idle;
          else if (sample_edge)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_BITS'(WORD_BITS - 1))
              state <= st_finish;
          end
        st_finish:
          state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  assign port.start = (state == st_start);
  assign busy       = (state == st_start) || (state == st_shift);

  // ----------------------------------------------------------------------
  // shifters
  // ----------------------------------------------------------------------

  // no reply queued means all ones
  assign load_word = port.tx_load ? port.tx_word : '1;

  always_ff @(posedge sendclk)
  begin
    if (state == st_start)
    begin
      // cpha 0 puts the msb on miso right away
      if (cpha)
        tx_shift <= load_word;
      else
        tx_shift <= {load_word[WORD_BITS-2:0], 1'b1};
    end
    else if (state == st_shift && shift_edge)
      tx_shift <= {tx_shift[WORD_BITS-2:0], 1'b1};

    if (state == st_shift && sample_edge)
      rx_shift <= {rx_shift[WORD_BITS-2:0], mosi_sync[1]};
  end

  always_ff @(posedge sendclk)
  begin
    if (reset)
      miso_q <= 1'b0;
    else if (state == st_start && !cpha)
      miso_q <= load_word[WORD_BITS-1];
    else if (state == st_shift && shift_edge)
      miso_q <= tx_shift[WORD_BITS-1];
  end

  assign miso = miso_q;

  // ----------------------------------------------------------------------
  // receive holding register
  // ----------------------------------------------------------------------

  always_ff @(posedge sendclk)
  begin
    if (reset)
    begin
      rx_valid_q   <= 1'b0;
      rx_overrun_q <= 1'b0;
    end
    else if (state == st_finish)
    begin
      rx_valid_q   <= 1'b1;
      // an old word not yet taken is lost
      rx_overrun_q <= rx_valid_q & ~port.rx_ready;
    end
    else if (port.rx_ready)
      rx_valid_q <= 1'b0;
  end

  always_ff @(posedge sendclk)
  begin
    if (state == st_finish)
      rx_hold <= rx_shift;
  end

  assign port.rx_word    = rx_hold;
  assign port.rx_valid   = rx_valid_q;
  assign port.rx_overrun = rx_overrun_q;

  a_start_one_cycle: assert property (
    @(posedge sendclk) disable iff (reset)
    port.start |=> !port.start
  ) else $error("start lasted more than one cycle");

  a_rx_word_stable: assert property (
    @(posedge sendclk) disable iff (reset)
    port.rx_valid && !port.rx_ready |=> $stable(port.rx_word) || port.rx_overrun
  ) else $error("rx_word changed while waiting for rx_ready");

endmodule
